/* armCore.sv */
`timescale 1ns/10ps

module armCore (
    input  logic                          CLK,
    input  logic                          rstN,
    input  logic [31:0]                   instr,
    input  logic                          instrValid,
    output logic                          instrReady,
    output logic [cpuPkg::REG_ADDR_W-1:0] wbAddr,
    output logic [31:0]                   wbData,
    output logic                          wbValid,
    input  logic                          wbReady
);

    // decode stage
    logic [cpuPkg::REG_ADDR_W-1:0] ra1D;
    logic [cpuPkg::REG_ADDR_W-1:0] ra2D;
    logic [cpuPkg::REG_ADDR_W-1:0] waD;
    logic [31:0]                   rd1D;
    logic [31:0]                   rd2D;
    logic [31:0]                   extImmD;
    cpuPkg::aluOpT                 aluOpD;
    cpuPkg::condT                  condD;
    logic                          aluSrcD;
    logic                          regWriteD;
    logic                          flagWriteD;
    logic                          isValidOpD;
    logic                          validD;

    // execute stage
    logic                          validE;
    logic [cpuPkg::REG_ADDR_W-1:0] ra1E;
    logic [cpuPkg::REG_ADDR_W-1:0] ra2E;
    logic [cpuPkg::REG_ADDR_W-1:0] waE;
    logic [31:0]                   rd1E;
    logic [31:0]                   rd2E;
    logic [31:0]                   extImmE;
    cpuPkg::aluOpT                 aluOpE;
    cpuPkg::condT                  condE;
    logic                          aluSrcE;
    logic                          regWriteE;
    logic                          flagWriteE;

    logic                          advance;
    logic                          fwd1;
    logic                          fwd2;
    logic                          regWe;

    assign instrReady = advance;
    // a no-op enters E as a bubble
    assign validD     = instrValid && isValidOpD;
    assign regWe      = wbValid && wbReady;

    instrDecoder u_instrDecoder (
        .instr     (instr),
        .ra1       (ra1D),
        .ra2       (ra2D),
        .wa        (waD),
        .extImm    (extImmD),
        .aluOp     (aluOpD),
        .cond      (condD),
        .aluSrc    (aluSrcD),
        .regWrite  (regWriteD),
        .flagWrite (flagWriteD),
        .isValidOp (isValidOpD)
    );

    regFile u_regFile (
        .CLK  (CLK),
        .rstN (rstN),
        .ra1  (ra1D),
        .ra2  (ra2D),
        .wa   (wbAddr),
        .wd   (wbData),
        .we   (regWe),
        .rd1  (rd1D),
        .rd2  (rd2D)
    );

    regDE u_regDE (
        .CLK        (CLK),
        .rstN       (rstN),
        .en         (advance),
        .validD     (validD),
        .ra1D       (ra1D),
        .ra2D       (ra2D),
        .waD        (waD),
        .rd1D       (rd1D),
        .rd2D       (rd2D),
        .extImmD    (extImmD),
        .aluOpD     (aluOpD),
        .condD      (condD),
        .aluSrcD    (aluSrcD),
        .regWriteD  (regWriteD),
        .flagWriteD (flagWriteD),
        .validE     (validE),
        .ra1E       (ra1E),
        .ra2E       (ra2E),
        .waE        (waE),
        .rd1E       (rd1E),
        .rd2E       (rd2E),
        .extImmE    (extImmE),
        .aluOpE     (aluOpE),
        .condE      (condE),
        .aluSrcE    (aluSrcE),
        .regWriteE  (regWriteE),
        .flagWriteE (flagWriteE)
    );

    hazardUnit u_hazardUnit (
        .ra1E    (ra1E),
        .ra2E    (ra2E),
        .wbAddr  (wbAddr),
        .wbValid (wbValid),
        .wbReady (wbReady),
        .advance (advance),
        .fwd1    (fwd1),
        .fwd2    (fwd2)
    );

    executeStage u_executeStage (
        .CLK        (CLK),
        .rstN       (rstN),
        .advance    (advance),
        .validE     (validE),
        .rd1E       (rd1E),
        .rd2E       (rd2E),
        .extImmE    (extImmE),
        .fwd1       (fwd1),
        .fwd2       (fwd2),
        .aluOpE     (aluOpE),
        .condE      (condE),
        .aluSrcE    (aluSrcE),
        .regWriteE  (regWriteE),
        .flagWriteE (flagWriteE),
        .waE        (waE),
        .wbReady    (wbReady),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .wbValid    (wbValid)
    );

endmodule

/* cpuPkg.sv */
package cpuPkg;

    // register file size
    localparam int NUM_REGS   = 16;
    localparam int REG_ADDR_W = 4;

    // *************************************************************************
    // data-processing instruction word, register and immediate views
    // *************************************************************************
    typedef struct packed {
        logic [3:0] cond;
        logic [1:0] opClass;
        logic       immFlag;
        logic [3:0] opcode;
        logic       sFlag;
        logic [3:0] rn;
        logic [3:0] rd;
        logic [7:0] shift;
        logic [3:0] rm;
    } dpRegT;

    typedef struct packed {
        logic [3:0] cond;
        logic [1:0] opClass;
        logic       immFlag;
        logic [3:0] opcode;
        logic       sFlag;
        logic [3:0] rn;
        logic [3:0] rd;
        logic [3:0] rot;
        logic [7:0] imm8;
    } dpImmT;

    typedef union packed {
        dpRegT dpReg;
        dpImmT dpImm;
    } instrT;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluRsb, aluAnd, aluOrr, aluEor, aluMov, aluMvn
    } aluOpT;

    // ARM encoding order, NV never executes
    typedef enum logic [3:0] {
        condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
        condHi, condLs, condGe, condLt, condGt, condLe, condAl, condNv
    } condT;

endpackage

/* executeStage.sv */
`timescale 1ns/10ps

module executeStage (
    input  logic                          CLK,
    input  logic                          rstN,
    input  logic                          advance,
    input  logic                          validE,
    input  logic [31:0]                   rd1E,
    input  logic [31:0]                   rd2E,
    input  logic [31:0]                   extImmE,
    input  logic                          fwd1,
    input  logic                          fwd2,
    input  cpuPkg::aluOpT                 aluOpE,
    input  cpuPkg::condT                  condE,
    input  logic                          aluSrcE,
    input  logic                          regWriteE,
    input  logic                          flagWriteE,
    input  logic [cpuPkg::REG_ADDR_W-1:0] waE,
    input  logic                          wbReady,
    output logic [cpuPkg::REG_ADDR_W-1:0] wbAddr,
    output logic [31:0]                   wbData,
    output logic                          wbValid
);

    logic [31:0] srcA;
    logic [31:0] regB;
    logic [31:0] srcB;
    logic [31:0] addX;
    logic [31:0] addY;
    logic        carryIn;
    logic [32:0] sum;
    logic [31:0] result;
    logic        isArith;
    logic        condPass;
    logic        flagN;
    logic        flagZ;
    logic        flagC;
    logic        flagV;

    assign srcA = fwd1 ? wbData : rd1E;
    assign regB = fwd2 ? wbData : rd2E;
    assign srcB = aluSrcE ? extImmE : regB;

    // *************************************************************************
    // condition check on NZCV
    // *************************************************************************
    always_comb
    begin
        case (condE)
            cpuPkg::condEq: condPass = flagZ;
            cpuPkg::condNe: condPass = !flagZ;
            cpuPkg::condCs: condPass = flagC;
            cpuPkg::condCc: condPass = !flagC;
            cpuPkg::condMi: condPass = flagN;
            cpuPkg::condPl: condPass = !flagN;
            cpuPkg::condVs: condPass = flagV;
            cpuPkg::condVc: condPass = !flagV;
            cpuPkg::condHi: condPass = flagC && !flagZ;
            cpuPkg::condLs: condPass = !flagC || flagZ;
            cpuPkg::condGe: condPass = (flagN == flagV);
            cpuPkg::condLt: condPass = (flagN != flagV);
            cpuPkg::condGt: condPass = !flagZ && (flagN == flagV);
            cpuPkg::condLe: condPass = flagZ || (flagN != flagV);
            cpuPkg::condAl: condPass = 1'b1;
            default:        condPass = 1'b0;
        endcase
    end

    // *************************************************************************
    // ALU, one adder serves add, sub and rsb
    // *************************************************************************
    always_comb
    begin
        addX    = srcA;
        addY    = srcB;
        carryIn = 1'b0;
        if (aluOpE == cpuPkg::aluSub)
        begin
            addY    = ~srcB;
            carryIn = 1'b1;
        end
        else if (aluOpE == cpuPkg::aluRsb)
        begin
            addX    = srcB;
            addY    = ~srcA;
            carryIn = 1'b1;
        end
    end

    assign sum     = {1'b0, addX} + {1'b0, addY} + {32'h0, carryIn};
    assign isArith = (aluOpE == cpuPkg::aluAdd) || (aluOpE == cpuPkg::aluSub) ||
                     (aluOpE == cpuPkg::aluRsb);

    always_comb
    begin
        case (aluOpE)
            cpuPkg::aluAnd: result = srcA & srcB;
            cpuPkg::aluOrr: result = srcA | srcB;
            cpuPkg::aluEor: result = srcA ^ srcB;
            cpuPkg::aluMov: result = srcB;
            cpuPkg::aluMvn: result = ~srcB;
            default:        result = sum[31:0];
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (!rstN)
        begin
            flagN <= 1'b0;
            flagZ <= 1'b0;
            flagC <= 1'b0;
            flagV <= 1'b0;
        end
        else if (advance && validE && condPass && flagWriteE)
        begin
            flagN <= result[31];
            flagZ <= (result == 32'h0);
            // logical ops leave C and V alone
            if (isArith)
            begin
                flagC <= sum[32];
                flagV <= (addX[31] == addY[31]) && (sum[31] != addX[31]);
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!rstN)
            wbValid <= 1'b0;
        else if (advance)
            wbValid <= validE && condPass && regWriteE;
    end

    always_ff @(posedge CLK)
    begin
        if (advance)
        begin
            wbAddr <= waE;
            wbData <= result;
        end
    end

    // held output stays put until the consumer takes it
    assert property (@(posedge CLK) disable iff (!rstN)
        (wbValid && !wbReady) |=> (wbValid && $stable(wbData) && $stable(wbAddr)));
    assert property (@(posedge CLK) !rstN |=> !wbValid);

endmodule

/* hazardUnit.sv */
`timescale 1ns/10ps

module hazardUnit (
    input  logic [cpuPkg::REG_ADDR_W-1:0] ra1E,
    input  logic [cpuPkg::REG_ADDR_W-1:0] ra2E,
    input  logic [cpuPkg::REG_ADDR_W-1:0] wbAddr,
    input  logic                          wbValid,
    input  logic                          wbReady,
    output logic                          advance,
    output logic                          fwd1,
    output logic                          fwd2
);

    // the whole pipeline moves only when the output slot can drain
    assign advance = !wbValid || wbReady;

    // held result not yet in the register file
    assign fwd1 = wbValid && (ra1E == wbAddr);
    assign fwd2 = wbValid && (ra2E == wbAddr);

endmodule

/* instrDecoder.sv */
`timescale 1ns/10ps

module instrDecoder (
    input  cpuPkg::instrT                  instr,
    output logic [cpuPkg::REG_ADDR_W-1:0]  ra1,
    output logic [cpuPkg::REG_ADDR_W-1:0]  ra2,
    output logic [cpuPkg::REG_ADDR_W-1:0]  wa,
    output logic [31:0]                    extImm,
    output cpuPkg::aluOpT                  aluOp,
    output cpuPkg::condT                   cond,
    output logic                           aluSrc,
    output logic                           regWrite,
    output logic                           flagWrite,
    output logic                           isValidOp
);

    // ARM data-processing opcodes
    localparam logic [3:0] OP_AND = 4'b0000;
    localparam logic [3:0] OP_EOR = 4'b0001;
    localparam logic [3:0] OP_SUB = 4'b0010;
    localparam logic [3:0] OP_RSB = 4'b0011;
    localparam logic [3:0] OP_ADD = 4'b0100;
    localparam logic [3:0] OP_CMP = 4'b1010;
    localparam logic [3:0] OP_ORR = 4'b1100;
    localparam logic [3:0] OP_MOV = 4'b1101;
    localparam logic [3:0] OP_MVN = 4'b1111;

    logic [31:0] immZext;
    logic [4:0]  rotAmt;
    logic [63:0] immRot;
    logic        isCmp;

    assign ra1    = instr.dpReg.rn;
    assign ra2    = instr.dpReg.rm;
    assign wa     = instr.dpReg.rd;
    assign cond   = cpuPkg::condT'(instr.dpReg.cond);
    assign aluSrc = instr.dpImm.immFlag;

    // imm8 rotated right by twice the rot field
    assign immZext = {24'h0, instr.dpImm.imm8};
    assign rotAmt  = {instr.dpImm.rot, 1'b0};
    assign immRot  = {immZext, immZext} >> rotAmt;
    assign extImm  = immRot[31:0];

    always_comb
    begin
        isValidOp = 1'b1;
        isCmp     = 1'b0;
        aluOp     = cpuPkg::aluAdd;
        case (instr.dpReg.opcode)
            OP_AND: aluOp = cpuPkg::aluAnd;
            OP_EOR: aluOp = cpuPkg::aluEor;
            OP_SUB: aluOp = cpuPkg::aluSub;
            OP_RSB: aluOp = cpuPkg::aluRsb;
            OP_ADD: aluOp = cpuPkg::aluAdd;
            OP_ORR: aluOp = cpuPkg::aluOrr;
            OP_MOV: aluOp = cpuPkg::aluMov;
            OP_MVN: aluOp = cpuPkg::aluMvn;
            OP_CMP:
            begin
                aluOp = cpuPkg::aluSub;
                isCmp = 1'b1;
            end
            default: isValidOp = 1'b0;
        endcase
        // anything outside the data-processing class is a no-op
        if (instr.dpReg.opClass != 2'b00)
            isValidOp = 1'b0;
    end

    assign regWrite  = isValidOp && !isCmp;
    assign flagWrite = isValidOp && (isCmp || instr.dpReg.sFlag);

endmodule

/* regDE.sv */
`timescale 1ns/10ps

module regDE (
    input  logic                          CLK,
    input  logic                          rstN,
    input  logic                          en,
    input  logic                          validD,
    input  logic [cpuPkg::REG_ADDR_W-1:0] ra1D,
    input  logic [cpuPkg::REG_ADDR_W-1:0] ra2D,
    input  logic [cpuPkg::REG_ADDR_W-1:0] waD,
    input  logic [31:0]                   rd1D,
    input  logic [31:0]                   rd2D,
    input  logic [31:0]                   extImmD,
    input  cpuPkg::aluOpT                 aluOpD,
    input  cpuPkg::condT                  condD,
    input  logic                          aluSrcD,
    input  logic                          regWriteD,
    input  logic                          flagWriteD,
    output logic                          validE,
    output logic [cpuPkg::REG_ADDR_W-1:0] ra1E,
    output logic [cpuPkg::REG_ADDR_W-1:0] ra2E,
    output logic [cpuPkg::REG_ADDR_W-1:0] waE,
    output logic [31:0]                   rd1E,
    output logic [31:0]                   rd2E,
    output logic [31:0]                   extImmE,
    output cpuPkg::aluOpT                 aluOpE,
    output cpuPkg::condT                  condE,
    output logic                          aluSrcE,
    output logic                          regWriteE,
    output logic                          flagWriteE
);

    always_ff @(posedge CLK)
    begin
        if (!rstN)
        begin
            validE     <= 1'b0;
            ra1E       <= '0;
            ra2E       <= '0;
            waE        <= '0;
            rd1E       <= '0;
            rd2E       <= '0;
            extImmE    <= '0;
            aluOpE     <= cpuPkg::aluAdd;
            condE      <= cpuPkg::condAl;
            aluSrcE    <= 1'b0;
            regWriteE  <= 1'b0;
            flagWriteE <= 1'b0;
        end
        else if (en)
        begin
            validE     <= validD;
            ra1E       <= ra1D;
            ra2E       <= ra2D;
            waE        <= waD;
            rd1E       <= rd1D;
            rd2E       <= rd2D;
            extImmE    <= extImmD;
            aluOpE     <= aluOpD;
            condE      <= condD;
            aluSrcE    <= aluSrcD;
            regWriteE  <= regWriteD;
            flagWriteE <= flagWriteD;
        end
    end

    // the E slot only fills from an accepted, decodable instruction
    assert property (@(posedge CLK) !rstN |=> !validE);
    assert property (@(posedge CLK) disable iff (!rstN) $rose(validE) |-> $past(en && validD));

endmodule

/* regFile.sv */
`timescale 1ns/10ps

module regFile (
    input  logic                          CLK,
    input  logic                          rstN,
    input  logic [cpuPkg::REG_ADDR_W-1:0] ra1,
    input  logic [cpuPkg::REG_ADDR_W-1:0] ra2,
    input  logic [cpuPkg::REG_ADDR_W-1:0] wa,
    input  logic [31:0]                   wd,
    input  logic                          we,
    output logic [31:0]                   rd1,
    output logic [31:0]                   rd2
);

    logic [31:0] regs [cpuPkg::NUM_REGS];

    always_ff @(posedge CLK)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < cpuPkg::NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (we)
        begin
            regs[wa] <= wd;
        end
    end

    // same-cycle write shows up on the read ports
    assign rd1 = (we && (wa == ra1)) ? wd : regs[ra1];
    assign rd2 = (we && (wa == ra2)) ? wd : regs[ra2];

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the armCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tbArmCore --Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/VtbArmCore
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished cleanly"
exit 0

/* tbArmModel.svh */
`ifndef TB_ARM_MODEL_SVH
`define TB_ARM_MODEL_SVH

// ****************************************************************************
// reference model, architectural state in program order
// ****************************************************************************
logic [31:0] modelRegs [16];
logic        mN;
logic        mZ;
logic        mC;
logic        mV;
// expected writebacks, {rd, data}
logic [35:0] expQ [$];

task automatic resetModel();
    for (int i = 0; i < 16; i++)
        modelRegs[i] = 32'h0;
    mN = 1'b0;
    mZ = 1'b0;
    mC = 1'b0;
    mV = 1'b0;
    expQ.delete();
endtask

function automatic logic [31:0] rotImm(input logic [7:0] imm8, input logic [3:0] rot);
    logic [31:0] v;
    v = {24'h0, imm8};
    for (int i = 0; i < 2 * rot; i++)
        v = {v[0], v[31:1]};
    return v;
endfunction

// pairs of ARM conditions share a base test, the low bit inverts it
function automatic logic condHolds(input logic [3:0] c);
    logic base;
    case (c[3:1])
        3'd0:    base = mZ;
        3'd1:    base = mC;
        3'd2:    base = mN;
        3'd3:    base = mV;
        3'd4:    base = mC && !mZ;
        3'd5:    base = (mN == mV);
        3'd6:    base = !mZ && (mN == mV);
        default: base = 1'b1;
    endcase
    if (c == cpuPkg::condNv)
        return 1'b0;
    else if (c == cpuPkg::condAl)
        return 1'b1;
    else
        return base ^ c[0];
endfunction

task automatic modelExecute(input logic [31:0] w);
    logic [3:0]  opc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [32:0] wide;
    logic        cOut;
    logic        vOut;
    logic        known;
    opc   = w[24:21];
    a     = modelRegs[w[19:16]];
    b     = w[25] ? rotImm(w[7:0], w[11:8]) : modelRegs[w[3:0]];
    res   = 32'h0;
    cOut  = mC;
    vOut  = mV;
    known = (w[27:26] == 2'b00);
    case (opc)
        4'b0000: res = a & b;
        4'b0001: res = a ^ b;
        4'b1100: res = a | b;
        4'b1101: res = b;
        4'b1111: res = ~b;
        4'b0010, 4'b1010:
        begin
            res  = a - b;
            cOut = (a >= b);
            vOut = (a[31] != b[31]) && (res[31] != a[31]);
        end
        4'b0011:
        begin
            res  = b - a;
            cOut = (b >= a);
            vOut = (a[31] != b[31]) && (res[31] != b[31]);
        end
        4'b0100:
        begin
            wide = {1'b0, a} + {1'b0, b};
            res  = wide[31:0];
            cOut = wide[32];
            vOut = (a[31] == b[31]) && (res[31] != a[31]);
        end
        default: known = 1'b0;
    endcase
    if (!known || !condHolds(w[31:28]))
        return;
    if (opc == 4'b1010 || w[20])
    begin
        mN = res[31];
        mZ = (res == 32'h0);
        mC = cOut;
        mV = vOut;
    end
    if (opc != 4'b1010)
    begin
        modelRegs[w[15:12]] = res;
        expQ.push_back({w[15:12], res});
    end
endtask

`endif

/* tbArmCore.sv */
`timescale 1ns/10ps

module tbArmCore;

    localparam int CLK_PERIOD   = 8;
    localparam int NUM_INSTR    = 400;
    localparam int DRAIN_CYCLES = 6;
    localparam int TIMEOUT_NS   = NUM_INSTR * 8 * CLK_PERIOD;

    logic        CLK;
    logic        rstN;
    logic [31:0] instr;
    logic        instrValid;
    logic        instrReady;
    logic [3:0]  wbAddr;
    logic [31:0] wbData;
    logic        wbValid;
    logic        wbReady;

    integer      seed;
    int          generated;
    int          accepted;
    int          checked;
    logic        tookInstr;
    logic        holding;
    logic [3:0]  heldAddr;
    logic [31:0] heldData;

    `include "tbArmModel.svh"

    armCore u_armCore (
        .CLK        (CLK),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .wbValid    (wbValid),
        .wbReady    (wbReady)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // ************************************************************************
    // checking and stopping
    // ************************************************************************
    task automatic stopWithFailure();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkEqual(input logic [31:0] got, input logic [31:0] want,
                              input string what);
        if (got !== want)
        begin
            $display("MISMATCH at %0t: %s, got 0x%08h, expected 0x%08h",
                     $time, what, got, want);
            stopWithFailure();
        end
    endtask

    // ************************************************************************
    // random stimulus
    // ************************************************************************
    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    function automatic int unsigned randBelow(input int unsigned n);
        return randWord() % n;
    endfunction

    // low registers most of the time so dependencies show up often
    function automatic logic [3:0] regPick();
        if (randBelow(8) == 0)
            return 4'(randBelow(16));
        return 4'(randBelow(8));
    endfunction

    function automatic logic [3:0] supportedOpcode(input int unsigned k);
        case (k)
            0:       return 4'b0000;
            1:       return 4'b0001;
            2:       return 4'b0010;
            3:       return 4'b0011;
            4:       return 4'b0100;
            5:       return 4'b1100;
            6:       return 4'b1101;
            7:       return 4'b1111;
            default: return 4'b1010;
        endcase
    endfunction

    // ADC, SBC, RSC, TST, TEQ, CMN, BIC
    function automatic logic [3:0] unsupportedOpcode(input int unsigned k);
        case (k)
            0:       return 4'b0101;
            1:       return 4'b0110;
            2:       return 4'b0111;
            3:       return 4'b1000;
            4:       return 4'b1001;
            5:       return 4'b1011;
            default: return 4'b1110;
        endcase
    endfunction

    function automatic logic [31:0] makeInstr();
        logic [3:0]  cond;
        logic [3:0]  opc;
        logic [1:0]  cls;
        logic        immForm;
        logic [11:0] op2;
        cond    = (randBelow(3) == 0) ? 4'(randBelow(16)) : 4'hE;
        immForm = (randBelow(2) == 1);
        opc     = supportedOpcode(randBelow(9));
        cls     = 2'b00;
        if (randBelow(20) == 0)
        begin
            if (randBelow(2) == 0)
                cls = 2'(randBelow(3) + 1);
            else
                opc = unsupportedOpcode(randBelow(7));
        end
        if (immForm)
            op2 = {4'(randBelow(16)), 8'(randBelow(256))};
        else
            op2 = {8'(randBelow(256)), regPick()};
        return {cond, cls, immForm, opc, 1'(randBelow(2)), regPick(), regPick(), op2};
    endfunction

    task automatic driveInputs();
        if (!instrValid || tookInstr)
        begin
            if (generated < NUM_INSTR && randBelow(4) != 0)
            begin
                instr      = makeInstr();
                instrValid = 1'b1;
                generated++;
            end
            else
            begin
                instr      = randWord();
                instrValid = 1'b0;
            end
        end
        wbReady = (randBelow(10) >= 3);
    endtask

    // mid-cycle, all ports settled
    task automatic checkCycle();
        logic [35:0] pair;
        tookInstr = instrValid && instrReady;
        if (tookInstr)
        begin
            modelExecute(instr);
            accepted++;
        end
        if (holding)
        begin
            checkEqual(32'(wbValid), 32'd1, "held wbValid dropped");
            checkEqual(32'(wbAddr), 32'(heldAddr), "held wbAddr changed");
            checkEqual(wbData, heldData, "held wbData changed");
        end
        // back-pressure freezes the pipeline and closes the input
        checkEqual(32'(instrReady), 32'(!(wbValid && !wbReady)), "instrReady");
        holding  = wbValid && !wbReady;
        heldAddr = wbAddr;
        heldData = wbData;
        if (wbValid && wbReady)
        begin
            if (expQ.size() == 0)
            begin
                $display("unexpected writeback to r%0d at %0t, no result was pending",
                         wbAddr, $time);
                stopWithFailure();
            end
            else
            begin
                pair = expQ.pop_front();
                checkEqual(32'(wbAddr), 32'(pair[35:32]), "writeback address");
                checkEqual(wbData, pair[31:0], "writeback data");
                checked++;
            end
        end
    endtask

    initial
    begin
        CLK        = 1'b0;
        rstN       = 1'b0;
        instr      = 32'h0;
        instrValid = 1'b0;
        wbReady    = 1'b0;
        seed       = 32'hb069_503a;
        generated  = 0;
        accepted   = 0;
        checked    = 0;
        tookInstr  = 1'b0;
        holding    = 1'b0;
        heldAddr   = 4'h0;
        heldData   = 32'h0;
        resetModel();
        repeat (4) @(posedge CLK);
        #1;
        rstN = 1'b1;
        @(negedge CLK);
        checkEqual(32'(wbValid), 32'd0, "wbValid after reset");
        checkEqual(32'(instrReady), 32'd1, "instrReady after reset");

        while (accepted < NUM_INSTR)
        begin
            @(posedge CLK);
            #1;
            driveInputs();
            @(negedge CLK);
            checkCycle();
        end

        // let the pipeline empty
        repeat (DRAIN_CYCLES)
        begin
            @(posedge CLK);
            #1;
            instrValid = 1'b0;
            wbReady    = 1'b1;
            @(negedge CLK);
            checkCycle();
        end

        $display("%0d instructions accepted, %0d writebacks checked", accepted, checked);
        if (expQ.size() != 0)
        begin
            $display("%0d expected writebacks never came out", expQ.size());
            stopWithFailure();
        end
        else
        begin
            $display("Done: no errors");
            $finish;
        end
    end

    // watchdog
    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        stopWithFailure();
    end

endmodule

/* verilog.f */
+incdir+.
cpuPkg.sv
instrDecoder.sv
regFile.sv
regDE.sv
hazardUnit.sv
executeStage.sv
armCore.sv
tbArmCore.sv
